// ==== hdl/simd_alu_macros.svh ====
////////////////////////////////////////
// SIMD ALU constants
// Widths, lane counts, credits, limits
////////////////////////////////////////
`ifndef SIMD_ALU_MACROS_SVH
`define SIMD_ALU_MACROS_SVH

// Data word and lane split
`define SIMD_XLEN        32
`define SIMD_BYTE_LANES  4
`define SIMD_HALF_LANES  2

// Flow control
`define SIMD_REQ_DEPTH   4
`define SIMD_OUT_CREDITS 2

// Lane saturation limits, two's complement patterns
`define SIMD_SAT_S8_MIN  8'h80
`define SIMD_SAT_S8_MAX  8'h7f
`define SIMD_SAT_S16_MIN 16'h8000
`define SIMD_SAT_S16_MAX 16'h7fff
`define SIMD_SAT_U8_MAX  8'hff
`define SIMD_SAT_U16_MAX 16'hffff

`endif

// ==== hdl/simd_alu_pkg.sv ====
////////////////////////////////////////
// SIMD ALU types
// Operation codes, lane word views and
// request, control and result structs
////////////////////////////////////////
`include "simd_alu_macros.svh"

package simd_alu_pkg;

  // Even codes are byte forms, odd codes halfword forms
  typedef enum logic [5:0] {
    ADD8,    ADD16,    SUB8,    SUB16,
    RADD8,   RADD16,   RSUB8,   RSUB16,
    KADD8,   KADD16,   KSUB8,   KSUB16,
    UKADD8,  UKADD16,  UKSUB8,  UKSUB16,
    CMPEQ8,  CMPEQ16,  SCMPLT8, SCMPLT16,
    UCMPLT8, UCMPLT16, SMIN8,   SMIN16,
    SMAX8,   SMAX16,   UMIN8,   UMIN16,
    UMAX8,   UMAX16,   SLL8,    SLL16,
    SRL8,    SRL16,    SRA8,    SRA16
  } simd_op_e;

  // One word, decoded as bytes or halfwords by lane width
  typedef union packed {
    logic [`SIMD_BYTE_LANES-1:0][`SIMD_XLEN/`SIMD_BYTE_LANES-1:0] bytes;
    logic [`SIMD_HALF_LANES-1:0][`SIMD_XLEN/`SIMD_HALF_LANES-1:0] halves;
  } simd_word_u;

  typedef struct packed {
    simd_op_e   op;
    simd_word_u a;
    simd_word_u b;
  } simd_req_t;

  typedef enum logic [1:0] {ADDER, COMPARE, MINMAX, SHIFT} simd_unit_e;

  typedef enum logic [1:0] {ADD_WRAP, ADD_HALVE, ADD_SAT} simd_add_mode_e;

  typedef enum logic [1:0] {SH_LEFT, SH_RLOG, SH_RARITH} simd_shift_e;

  typedef struct packed {
    logic           width8;
    logic           is_signed;
    logic           sub;
    simd_add_mode_e add_mode;
    logic           cmp_less;    // Less-than mask, else equal mask
    logic           is_max;
    simd_shift_e    shift_kind;
    simd_unit_e     unit;
  } simd_ctrl_t;

  typedef struct packed {
    logic [`SIMD_XLEN-1:0] data;
    logic                  ov;
  } simd_result_t;

endpackage

// ==== hdl/simd_alu_top.sv ====
////////////////////////////////////////
// Packed-SIMD ALU top
// Credit queue, decode stage, units and
// registered result with output credits
////////////////////////////////////////
`timescale 1ns/1ps
`include "simd_alu_macros.svh"

module simd_alu_top (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       req_valid_i,
  input  simd_alu_pkg::simd_req_t    req_i,
  output logic                       req_credit_o,
  output logic                       rsp_valid_o,
  output simd_alu_pkg::simd_result_t rsp_o,
  input  logic                       rsp_credit_i
);

  localparam int CNT_W = $clog2(`SIMD_OUT_CREDITS + 1);

  simd_alu_pkg::simd_req_t  head;
  logic                     not_empty;
  logic                     pop;
  logic [CNT_W-1:0]         credit_cnt;
  simd_alu_pkg::simd_ctrl_t dec_ctrl;

  logic                     s1_valid;
  simd_alu_pkg::simd_ctrl_t s1_ctrl;
  simd_alu_pkg::simd_word_u s1_a;
  simd_alu_pkg::simd_word_u s1_b;

  logic [`SIMD_XLEN-1:0]    add_sum;
  logic                     add_ov;
  logic [`SIMD_XLEN-1:0]    cmp_mask;
  logic [`SIMD_XLEN-1:0]    cmp_minmax;
  logic [`SIMD_XLEN-1:0]    shift_res;
  simd_alu_pkg::simd_result_t res;

  simd_req_queue i_queue (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .push_i       (req_valid_i),
    .push_data_i  (req_i),
    .pop_i        (pop),
    .head_o       (head),
    .not_empty_o  (not_empty),
    .req_credit_o (req_credit_o)
  );

  ////////////////////////////////////////
  // Release and output credits
  ////////////////////////////////////////
  // A release reserves one output slot
  assign pop = not_empty && (credit_cnt != '0);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      credit_cnt <= CNT_W'(`SIMD_OUT_CREDITS);
    end else if (pop && !rsp_credit_i) begin
      credit_cnt <= credit_cnt - 1'b1;
    end else if (!pop && rsp_credit_i) begin
      credit_cnt <= credit_cnt + 1'b1;
    end
  end

  ////////////////////////////////////////
  // Stage 1 decode register
  ////////////////////////////////////////
  simd_op_decoder i_decoder (
    .op_i   (head.op),
    .ctrl_o (dec_ctrl)
  );

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= pop;
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop) begin
      s1_ctrl <= dec_ctrl;
      s1_a    <= head.a;
      s1_b    <= head.b;
    end
  end

  // Lane units
  simd_lane_adder i_adder (
    .a_i    (s1_a),
    .b_i    (s1_b),
    .ctrl_i (s1_ctrl),
    .sum_o  (add_sum),
    .ov_o   (add_ov)
  );

  simd_lane_compare i_compare (
    .a_i      (s1_a),
    .b_i      (s1_b),
    .ctrl_i   (s1_ctrl),
    .mask_o   (cmp_mask),
    .minmax_o (cmp_minmax)
  );

  // Shift amount is the low nibble of operand b
  simd_lane_shifter i_shifter (
    .a_i     (s1_a),
    .amt_i   (s1_b.bytes[0][3:0]),
    .ctrl_i  (s1_ctrl),
    .shift_o (shift_res)
  );

  ////////////////////////////////////////
  // Stage 2 result mux and register
  ////////////////////////////////////////
  always_comb begin
    case (s1_ctrl.unit)
      simd_alu_pkg::COMPARE: res.data = cmp_mask;
      simd_alu_pkg::MINMAX:  res.data = cmp_minmax;
      simd_alu_pkg::SHIFT:   res.data = shift_res;
      default:               res.data = add_sum;
    endcase
    // Overflow only means something for saturating adds
    res.ov = add_ov && (s1_ctrl.unit == simd_alu_pkg::ADDER)
                    && (s1_ctrl.add_mode == simd_alu_pkg::ADD_SAT);
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rsp_valid_o <= 1'b0;
    end else begin
      rsp_valid_o <= s1_valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (s1_valid) begin
      rsp_o <= res;
    end
  end

endmodule

// ==== hdl/simd_lane_adder.sv ====
////////////////////////////////////////
// Lane adder
// Split-carry add/sub with wrap, halving
// and saturating results
////////////////////////////////////////
`timescale 1ns/1ps
`include "simd_alu_macros.svh"

module simd_lane_adder (
  input  simd_alu_pkg::simd_word_u a_i,
  input  simd_alu_pkg::simd_word_u b_i,
  input  simd_alu_pkg::simd_ctrl_t ctrl_i,
  output logic [`SIMD_XLEN-1:0]    sum_o,
  output logic                     ov_o
);

  logic [`SIMD_XLEN-1:0]         b_x;
  logic [`SIMD_BYTE_LANES-1:0][8:0] bsum;
  logic [`SIMD_BYTE_LANES-1:0]   top;
  logic [`SIMD_BYTE_LANES-1:0]   s_ov;
  logic [`SIMD_BYTE_LANES-1:0]   u_ov;
  logic [`SIMD_BYTE_LANES-1:0]   clamp;
  logic [`SIMD_XLEN-1:0]         wrap_res;
  logic [`SIMD_XLEN-1:0]         half_res;
  logic [`SIMD_XLEN-1:0]         sat_res;
  logic [7:0]                    lim8;
  logic [15:0]                   lim16;
  logic                          carry;
  logic                          cin;

  // Subtract as a + ~b + 1
  assign b_x = ctrl_i.sub ? ~b_i : b_i;

  ////////////////////////////////////////
  // Byte adders
  ////////////////////////////////////////
  always_comb begin
    carry = 1'b0;
    for (int i = 0; i < `SIMD_BYTE_LANES; i++) begin
      // Carry crosses into odd bytes only inside a halfword lane
      cin     = (ctrl_i.width8 || (i % 2 == 0)) ? ctrl_i.sub : carry;
      bsum[i] = {1'b0, a_i.bytes[i]} + {1'b0, b_x[8*i +: 8]} + {8'd0, cin};
      carry   = bsum[i][8];
      // Ninth bit of the sign-extended result
      top[i]  = a_i.bytes[i][7] ^ b_x[8*i+7] ^ bsum[i][8];
      s_ov[i] = top[i] ^ bsum[i][7];
      // Carry out on add, missing carry (borrow) on sub
      u_ov[i] = bsum[i][8] ^ ctrl_i.sub;
      wrap_res[8*i +: 8] = bsum[i][7:0];
    end
  end

  ////////////////////////////////////////
  // Halving and saturation per lane
  ////////////////////////////////////////
  always_comb begin
    clamp = '0;
    lim8  = '0;
    lim16 = '0;
    if (ctrl_i.width8) begin
      for (int i = 0; i < `SIMD_BYTE_LANES; i++) begin
        half_res[8*i +: 8] = {top[i], bsum[i][7:1]};
        clamp[i] = ctrl_i.is_signed ? s_ov[i] : u_ov[i];
        if (ctrl_i.is_signed) begin
          lim8 = top[i] ? `SIMD_SAT_S8_MIN : `SIMD_SAT_S8_MAX;
        end else begin
          lim8 = ctrl_i.sub ? 8'h00 : `SIMD_SAT_U8_MAX;
        end
        sat_res[8*i +: 8] = clamp[i] ? lim8 : bsum[i][7:0];
      end
    end else begin
      for (int h = 0; h < `SIMD_HALF_LANES; h++) begin
        // Upper byte of each halfword holds the lane sign and carry
        half_res[16*h +: 16] = {top[2*h+1], bsum[2*h+1][7:0], bsum[2*h][7:1]};
        clamp[2*h+1] = ctrl_i.is_signed ? s_ov[2*h+1] : u_ov[2*h+1];
        if (ctrl_i.is_signed) begin
          lim16 = top[2*h+1] ? `SIMD_SAT_S16_MIN : `SIMD_SAT_S16_MAX;
        end else begin
          lim16 = ctrl_i.sub ? 16'h0000 : `SIMD_SAT_U16_MAX;
        end
        sat_res[16*h +: 16] = clamp[2*h+1] ? lim16 : {bsum[2*h+1][7:0], bsum[2*h][7:0]};
      end
    end
  end

  always_comb begin
    case (ctrl_i.add_mode)
      simd_alu_pkg::ADD_HALVE: sum_o = half_res;
      simd_alu_pkg::ADD_SAT:   sum_o = sat_res;
      default:                 sum_o = wrap_res;
    endcase
  end

  assign ov_o = |clamp;

endmodule

// ==== hdl/simd_lane_compare.sv ====
////////////////////////////////////////
// Lane comparator
// Equal and less-than masks, min/max
////////////////////////////////////////
`timescale 1ns/1ps
`include "simd_alu_macros.svh"

module simd_lane_compare (
  input  simd_alu_pkg::simd_word_u a_i,
  input  simd_alu_pkg::simd_word_u b_i,
  input  simd_alu_pkg::simd_ctrl_t ctrl_i,
  output logic [`SIMD_XLEN-1:0]    mask_o,
  output logic [`SIMD_XLEN-1:0]    minmax_o
);

  // One flag per byte, halfword results copied into both bytes
  logic [`SIMD_BYTE_LANES-1:0] eq;
  logic [`SIMD_BYTE_LANES-1:0] lt;
  logic [`SIMD_BYTE_LANES-1:0] hit;

  always_comb begin
    if (ctrl_i.width8) begin
      for (int i = 0; i < `SIMD_BYTE_LANES; i++) begin
        eq[i] = (a_i.bytes[i] == b_i.bytes[i]);
        lt[i] = ctrl_i.is_signed ? ($signed(a_i.bytes[i]) < $signed(b_i.bytes[i]))
                                 : (a_i.bytes[i] < b_i.bytes[i]);
      end
    end else begin
      for (int h = 0; h < `SIMD_HALF_LANES; h++) begin
        eq[2*h] = (a_i.halves[h] == b_i.halves[h]);
        lt[2*h] = ctrl_i.is_signed ? ($signed(a_i.halves[h]) < $signed(b_i.halves[h]))
                                   : (a_i.halves[h] < b_i.halves[h]);
        eq[2*h+1] = eq[2*h];
        lt[2*h+1] = lt[2*h];
      end
    end
  end

  assign hit = ctrl_i.cmp_less ? lt : eq;

  // Widen flags to lane masks and pick a or b per byte
  always_comb begin
    for (int i = 0; i < `SIMD_BYTE_LANES; i++) begin
      mask_o[8*i +: 8] = {8{hit[i]}};
      // Min keeps a when a < b, max keeps a otherwise
      minmax_o[8*i +: 8] = (lt[i] ^ ctrl_i.is_max) ? a_i.bytes[i] : b_i.bytes[i];
    end
  end

endmodule

// ==== hdl/simd_lane_shifter.sv ====
////////////////////////////////////////
// Lane shifter
// Per-lane SLL, SRL and SRA
////////////////////////////////////////
`timescale 1ns/1ps
`include "simd_alu_macros.svh"

module simd_lane_shifter (
  input  simd_alu_pkg::simd_word_u a_i,
  input  logic [3:0]               amt_i,
  input  simd_alu_pkg::simd_ctrl_t ctrl_i,
  output logic [`SIMD_XLEN-1:0]    shift_o
);

  // Each lane shifts on its own, so no bit leaves its lane and
  // arithmetic shifts see only the lane's own sign
  always_comb begin
    if (ctrl_i.width8) begin
      for (int i = 0; i < `SIMD_BYTE_LANES; i++) begin
        case (ctrl_i.shift_kind)
          simd_alu_pkg::SH_RLOG:
            shift_o[8*i +: 8] = a_i.bytes[i] >> amt_i[2:0];
          simd_alu_pkg::SH_RARITH:
            shift_o[8*i +: 8] = $signed(a_i.bytes[i]) >>> amt_i[2:0];
          default:
            shift_o[8*i +: 8] = a_i.bytes[i] << amt_i[2:0];
        endcase
      end
    end else begin
      for (int h = 0; h < `SIMD_HALF_LANES; h++) begin
        case (ctrl_i.shift_kind)
          simd_alu_pkg::SH_RLOG:
            shift_o[16*h +: 16] = a_i.halves[h] >> amt_i;
          simd_alu_pkg::SH_RARITH:
            shift_o[16*h +: 16] = $signed(a_i.halves[h]) >>> amt_i;
          default:
            shift_o[16*h +: 16] = a_i.halves[h] << amt_i;
        endcase
      end
    end
  end

endmodule

// ==== hdl/simd_op_decoder.sv ====
////////////////////////////////////////
// Operation decoder
// Op code to lane width, sign and unit
////////////////////////////////////////
`timescale 1ns/1ps

module simd_op_decoder (
  input  simd_alu_pkg::simd_op_e   op_i,
  output simd_alu_pkg::simd_ctrl_t ctrl_o
);

  always_comb begin
    ctrl_o            = '0;
    // Lane width sits in the low code bit
    ctrl_o.width8     = ~op_i[0];
    ctrl_o.add_mode   = simd_alu_pkg::ADD_WRAP;
    ctrl_o.shift_kind = simd_alu_pkg::SH_LEFT;
    ctrl_o.unit       = simd_alu_pkg::ADDER;

    case (op_i)
      simd_alu_pkg::SUB8, simd_alu_pkg::SUB16: begin
        ctrl_o.sub = 1'b1;
      end
      simd_alu_pkg::RADD8, simd_alu_pkg::RADD16: begin
        ctrl_o.is_signed = 1'b1;
        ctrl_o.add_mode  = simd_alu_pkg::ADD_HALVE;
      end
      simd_alu_pkg::RSUB8, simd_alu_pkg::RSUB16: begin
        ctrl_o.is_signed = 1'b1;
        ctrl_o.sub       = 1'b1;
        ctrl_o.add_mode  = simd_alu_pkg::ADD_HALVE;
      end
      simd_alu_pkg::KADD8, simd_alu_pkg::KADD16: begin
        ctrl_o.is_signed = 1'b1;
        ctrl_o.add_mode  = simd_alu_pkg::ADD_SAT;
      end
      simd_alu_pkg::KSUB8, simd_alu_pkg::KSUB16: begin
        ctrl_o.is_signed = 1'b1;
        ctrl_o.sub       = 1'b1;
        ctrl_o.add_mode  = simd_alu_pkg::ADD_SAT;
      end
      simd_alu_pkg::UKADD8, simd_alu_pkg::UKADD16: begin
        ctrl_o.add_mode = simd_alu_pkg::ADD_SAT;
      end
      simd_alu_pkg::UKSUB8, simd_alu_pkg::UKSUB16: begin
        ctrl_o.sub      = 1'b1;
        ctrl_o.add_mode = simd_alu_pkg::ADD_SAT;
      end

      // Compares
      simd_alu_pkg::CMPEQ8, simd_alu_pkg::CMPEQ16: begin
        ctrl_o.unit = simd_alu_pkg::COMPARE;
      end
      simd_alu_pkg::SCMPLT8, simd_alu_pkg::SCMPLT16: begin
        ctrl_o.unit      = simd_alu_pkg::COMPARE;
        ctrl_o.cmp_less  = 1'b1;
        ctrl_o.is_signed = 1'b1;
      end
      simd_alu_pkg::UCMPLT8, simd_alu_pkg::UCMPLT16: begin
        ctrl_o.unit     = simd_alu_pkg::COMPARE;
        ctrl_o.cmp_less = 1'b1;
      end

      // Min and max
      simd_alu_pkg::SMIN8, simd_alu_pkg::SMIN16: begin
        ctrl_o.unit      = simd_alu_pkg::MINMAX;
        ctrl_o.is_signed = 1'b1;
      end
      simd_alu_pkg::SMAX8, simd_alu_pkg::SMAX16: begin
        ctrl_o.unit      = simd_alu_pkg::MINMAX;
        ctrl_o.is_signed = 1'b1;
        ctrl_o.is_max    = 1'b1;
      end
      simd_alu_pkg::UMIN8, simd_alu_pkg::UMIN16: begin
        ctrl_o.unit = simd_alu_pkg::MINMAX;
      end
      simd_alu_pkg::UMAX8, simd_alu_pkg::UMAX16: begin
        ctrl_o.unit   = simd_alu_pkg::MINMAX;
        ctrl_o.is_max = 1'b1;
      end

      // Shifts
      simd_alu_pkg::SLL8, simd_alu_pkg::SLL16: begin
        ctrl_o.unit = simd_alu_pkg::SHIFT;
      end
      simd_alu_pkg::SRL8, simd_alu_pkg::SRL16: begin
        ctrl_o.unit       = simd_alu_pkg::SHIFT;
        ctrl_o.shift_kind = simd_alu_pkg::SH_RLOG;
      end
      simd_alu_pkg::SRA8, simd_alu_pkg::SRA16: begin
        ctrl_o.unit       = simd_alu_pkg::SHIFT;
        ctrl_o.shift_kind = simd_alu_pkg::SH_RARITH;
        ctrl_o.is_signed  = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

// ==== hdl/simd_req_queue.sv ====
////////////////////////////////////////
// Request queue
// Circular buffer, one credit per release
////////////////////////////////////////
`timescale 1ns/1ps
`include "simd_alu_macros.svh"

module simd_req_queue (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    push_i,
  input  simd_alu_pkg::simd_req_t push_data_i,
  input  logic                    pop_i,
  output simd_alu_pkg::simd_req_t head_o,
  output logic                    not_empty_o,
  output logic                    req_credit_o
);

  localparam int PTR_W = $clog2(`SIMD_REQ_DEPTH);

  simd_alu_pkg::simd_req_t mem [`SIMD_REQ_DEPTH];
  logic [PTR_W-1:0]        wr_ptr;
  logic [PTR_W-1:0]        rd_ptr;
  logic [PTR_W:0]          count;

  // Storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem[wr_ptr] <= push_data_i;
    end
  end

  // Pointers, fill level and credit return
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr       <= '0;
      rd_ptr       <= '0;
      count        <= '0;
      req_credit_o <= 1'b0;
    end else begin
      if (push_i) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop_i) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (push_i && !pop_i) begin
        count <= count + 1'b1;
      end else if (!push_i && pop_i) begin
        count <= count - 1'b1;
      end
      req_credit_o <= pop_i;
    end
  end

  assign head_o      = mem[rd_ptr];
  assign not_empty_o = (count != '0);

endmodule

// ==== run.sh ====
#!/bin/sh
# Build the SIMD ALU testbench with Verilator and run it.
# The exit status of the simulation is the exit status of this script.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
  -f src.f \
  --top-module tb_simd_alu_top \
  -o sim_tb_simd_alu_top

./obj_dir/sim_tb_simd_alu_top

// ==== src.f ====
+incdir+hdl
hdl/simd_alu_pkg.sv
hdl/simd_req_queue.sv
hdl/simd_op_decoder.sv
hdl/simd_lane_adder.sv
hdl/simd_lane_compare.sv
hdl/simd_lane_shifter.sv
hdl/simd_alu_top.sv
verif/tb_simd_alu_top.sv

// ==== verif/simd_alu_patterns.hex ====
// Columns: op code, operand a, operand b, expected data, expected overflow
// Op codes follow the operation enum order, ADD8 = 00 up to SRA16 = 23
00 7f80ff01 01800102 80000003 0
01 00ffffff 00010001 01000000 0
02 00108001 01207f02 fff001ff 0
03 00000100 00010001 ffff00ff 0
04 7f80ff05 7f800103 7f800004 0
04 fffe0103 fffd0000 fffd0001 0
05 7fff8000 7fff8000 7fff8000 0
06 807f0005 7f800100 807fff02 0
07 80000010 7fff0020 8000fff8 0
08 7f80107f 01ff2080 7f8030ff 1
08 10203040 01020304 11223344 0
09 7fff0001 00017ffe 7fff7fff 1
0a 80007f05 01800102 807f7e03 1
0b 80001234 00010234 80001000 1
0c ff80010f 01800203 ffff0312 1
0d fff01234 00101111 ffff2345 1
0e 01ff1000 02011000 00fe0000 1
0f 12340001 02340002 10000000 1
0f ffff8000 00018000 fffe0000 0
10 11223344 11003345 ff00ff00 0
11 1234abcd 1234abce ffff0000 0
12 80017fff 7f028000 ffff00ff 0
13 80000005 7fff0005 ffff0000 0
14 80017fff 7f028000 00ffff00 0
15 0001ffff 80000000 ffff0000 0
16 80057fff 7f0a8001 800580ff 0
17 12348000 1233ffff 12338000 0
18 80057fff 7f0a8001 7f0a7f01 0
19 80007fff 0001fffe 00017fff 0
1a 80057fff 7f0a8001 7f057f01 0
1b 80000001 7fffffff 7fff0001 0
1c 80057fff 7f0a8001 800a80ff 0
1d 80000001 7fffffff 8000ffff 0
1e 81ff0f01 00000003 08f87808 0
1e 81ff0f01 fffffffb 08f87808 0
1f 800100ff 00000004 00100ff0 0
20 80ff0f01 00000001 407f0700 0
21 8000ffff 0000000c 0008000f 0
22 80ff7f40 00000002 e0ff1f10 0
23 80007fff 0000000f ffff0000 0
23 ff000080 00000004 fff00008 0

// ==== verif/tb_simd_alu_top.sv ====
////////////////////////////////////////
// Testbench for the packed-SIMD ALU
// Pattern requests under producer credits,
// random consumer credits, ordered checks
////////////////////////////////////////
`timescale 1ns/1ps
`include "simd_alu_macros.svh"

module tb_simd_alu_top;

  localparam int          NUM_PATTERNS   = 41;
  localparam int          FIELDS         = 5;
  localparam int          ADDR_W         = $clog2(NUM_PATTERNS * FIELDS);
  localparam int          TIMEOUT_CYCLES = 20 * NUM_PATTERNS + 100;
  localparam logic [31:0] SEED           = 32'hee25c90b;

  logic                       clk;
  logic                       rst_n;
  logic                       req_valid;
  simd_alu_pkg::simd_req_t    req;
  logic                       req_credit;
  logic                       rsp_valid;
  simd_alu_pkg::simd_result_t rsp;
  logic                       rsp_credit;

  // Per pattern: op, a, b, expected data, expected overflow
  logic [31:0] pattern_mem [NUM_PATTERNS * FIELDS];

  int sent             = 0;
  int credit_returns   = 0;
  int rsp_count        = 0;
  int rsp_credit_count = 0;
  int credits_given    = 0;
  int cycle_count      = 0;

  simd_alu_top i_dut (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .req_valid_i  (req_valid),
    .req_i        (req),
    .req_credit_o (req_credit),
    .rsp_valid_o  (rsp_valid),
    .rsp_o        (rsp),
    .rsp_credit_i (rsp_credit)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] pattern_field(int idx, int sel);
    return pattern_mem[ADDR_W'(FIELDS * idx + sel)];
  endfunction

  task automatic stop_run();
    $display("Simulation failed");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic check_value(string name, logic [31:0] actual, logic [31:0] expected);
    if (actual !== expected) begin
      $display("FAILED at %0d ns: %s got 0x%08h expected 0x%08h",
               $time, name, actual, expected);
      stop_run();
    end
  endtask

  ////////////////////////////////////////
  // Reset, driver and end of run
  ////////////////////////////////////////
  initial begin : main_seq
    simd_alu_pkg::simd_req_t next_req;
    logic [31:0]             op_word;

    rst_n     = 1'b0;
    req_valid = 1'b0;
    req       = '0;
    $readmemh("verif/simd_alu_patterns.hex", pattern_mem);

    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    // Outputs idle right after reset
    @(negedge clk);
    check_value("rsp_valid_o", 32'(rsp_valid), 32'd0);
    check_value("req_credit_o", 32'(req_credit), 32'd0);

    // One request per cycle while producer credits remain
    while (sent < NUM_PATTERNS) begin
      @(posedge clk);
      if (sent - credit_returns < `SIMD_REQ_DEPTH) begin
        op_word     = pattern_field(sent, 0);
        next_req.op = simd_alu_pkg::simd_op_e'(op_word[5:0]);
        next_req.a  = pattern_field(sent, 1);
        next_req.b  = pattern_field(sent, 2);
        req_valid  <= 1'b1;
        req        <= next_req;
        sent        = sent + 1;
      end else begin
        req_valid <= 1'b0;
      end
    end
    @(posedge clk);
    req_valid <= 1'b0;

    wait (rsp_count == NUM_PATTERNS);
    // Room for a stray extra result to show up
    repeat (6) @(posedge clk);
    if (rsp_count == NUM_PATTERNS && credit_returns == NUM_PATTERNS) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      $display("Wrong totals at the end: %0d results and %0d request credits for %0d patterns",
               rsp_count, credit_returns, NUM_PATTERNS);
      stop_run();
    end
  end

  // Consumer hands back one credit per result after 0 to 3 cycles
  initial begin : consumer
    int delay;

    void'($urandom(SEED));
    rsp_credit = 1'b0;
    forever begin
      @(posedge clk);
      rsp_credit <= 1'b0;
      if (credits_given < rsp_count) begin
        delay = $urandom % 4;
        repeat (delay) @(posedge clk);
        rsp_credit    <= 1'b1;
        credits_given  = credits_given + 1;
      end
    end
  end

  ////////////////////////////////////////
  // Scoreboard and credit accounting
  ////////////////////////////////////////
  always @(negedge clk) begin
    if (rst_n) begin
      if (req_credit) begin
        credit_returns = credit_returns + 1;
        check_value("req_credit_o beyond requests sent", 32'(credit_returns > sent), 32'd0);
      end
      if (rsp_credit) begin
        rsp_credit_count = rsp_credit_count + 1;
      end
      if (rsp_valid) begin
        if (rsp_count >= NUM_PATTERNS) begin
          $display("A result arrived after all %0d patterns were already checked",
                   NUM_PATTERNS);
          stop_run();
        end else begin
          check_value($sformatf("rsp_o.data (pattern %0d)", rsp_count),
                      rsp.data, pattern_field(rsp_count, 3));
          check_value($sformatf("rsp_o.ov (pattern %0d)", rsp_count),
                      32'(rsp.ov), pattern_field(rsp_count, 4));
          rsp_count = rsp_count + 1;
          // Results never outrun the consumer credits
          check_value("rsp_valid_o beyond consumer credits",
                      32'(rsp_count > rsp_credit_count + `SIMD_OUT_CREDITS), 32'd0);
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles with %0d of %0d results checked",
               cycle_count, rsp_count, NUM_PATTERNS);
      stop_run();
    end
  end

endmodule
